//--- compile.f
+incdir+dv
verilog/rv32i_pkg.sv
verilog/ctrl_word.sv
verilog/regfile.sv
verilog/alu.sv
verilog/hazard_ctrl.sv
verilog/datapath.sv
verilog/rv32i_cpu.sv
dv/rv32i_cpu_tb.sv

//--- dv/rv32i_ref.svh
`ifndef RV32I_REF_SVH
`define RV32I_REF_SVH

typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  rd;
    logic [31:0] data;
} commit_t;

typedef struct packed {
    logic [31:0] addr;
    logic [3:0]  rmask;
    logic [3:0]  wmask;
    logic [31:0] wdata;
} access_t;

localparam int          PROG_LEN   = 200;
localparam int          IMEM_WORDS = 256;            // Program plus padding
localparam logic [31:0] NOP_INSTR  = 32'h0000_0013;  // addi x0, x0, 0

logic [31:0] prog [IMEM_WORDS];
logic [7:0]  ref_mem [256];
commit_t     exp_commit_q [$];
access_t     exp_mem_q [$];

// Odd multiplier, so every byte address gets its own start value
function automatic logic [7:0] fill_byte(int addr);
    return 8'(addr * 29 + 8'h5c);
endfunction

function automatic logic [3:0] lane_mask(logic [2:0] f3, logic [1:0] lo);
    case (f3[1:0])
        2'd0:    return 4'b0001 << lo;
        2'd1:    return 4'b0011 << lo;
        default: return 4'b1111;
    endcase
endfunction

function automatic logic [31:0] rand_instr();
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    rd  = 5'($urandom % 8);  // Few registers, so dependencies are frequent
    rs1 = 5'($urandom % 8);
    rs2 = 5'($urandom % 8);
    f3  = 3'($urandom);
    imm = 12'($urandom);
    case ($urandom % 10)
        0: return {imm, rs1, f3, rd, rv32i_pkg::op_lui};
        1: return {imm, rs1, f3, rd, rv32i_pkg::op_auipc};
        2, 3, 4: begin
            if (f3 == 3'b001) imm = {7'b0, imm[4:0]};
            if (f3 == 3'b101) imm = {1'b0, imm[10], 5'b0, imm[4:0]};  // SRLI or SRAI
            return {imm, rs1, f3, rd, rv32i_pkg::op_imm};
        end
        5, 6: begin
            if (f3 != 3'b000 && f3 != 3'b101) imm[10] = 1'b0;  // Only SUB and SRA
            return {1'b0, imm[10], 5'b0, rs2, rs1, f3, rd, rv32i_pkg::op_reg};
        end
        7, 8: begin
            f3 = 3'($urandom % 5);
            if (f3 > 3'd2) f3 = f3 + 3'd1;
            imm = {4'b0, imm[7:0]} & ~12'((1 << f3[1:0]) - 1);
            return {imm, 5'd0, f3, rd, rv32i_pkg::op_load};
        end
        default: begin
            f3  = 3'($urandom % 3);
            imm = {4'b0, imm[7:0]} & ~12'((1 << f3[1:0]) - 1);
            return {imm[11:5], rs2, 5'd0, f3, imm[4:0], rv32i_pkg::op_store};
        end
    endcase
endfunction

function automatic void gen_program();
    for (int i = 0; i < IMEM_WORDS; i++) begin
        prog[i] = (i < PROG_LEN) ? rand_instr() : NOP_INSTR;
    end
endfunction

function automatic logic [31:0] alu_ref(logic [2:0] f3, logic alt, logic [31:0] a,
                                        logic [31:0] b);
    case (f3)
        3'b000: return alt ? a - b : a + b;
        3'b001: return a << b[4:0];
        3'b010: return {31'b0, $signed(a) < $signed(b)};
        3'b011: return {31'b0, a < b};
        3'b100: return a ^ b;
        3'b101: begin
            if (alt) begin
                return $signed(a) >>> b[4:0];
            end else begin
                return a >> b[4:0];
            end
        end
        3'b110: return a | b;
        default: return a & b;
    endcase
endfunction

// Runs the image in order and records every retirement and data access
function automatic void run_model();
    logic [31:0] x [32];
    logic [31:0] ins;
    logic [31:0] pc;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] addr;
    logic [31:0] word;
    logic [3:0]  lanes;
    logic [4:0]  rd;
    logic [2:0]  f3;
    for (int r = 0; r < 32; r++) begin
        x[r] = '0;
    end
    for (int i = 0; i < IMEM_WORDS; i++) begin
        ins = prog[i];
        pc  = rv32i_pkg::PC_RESET + 32'(4 * i);
        rd  = ins[11:7];
        f3  = ins[14:12];
        a   = x[ins[19:15]];
        b   = {{20{ins[31]}}, ins[31:20]};
        case (ins[6:0])
            rv32i_pkg::op_lui:   res = {ins[31:12], 12'b0};
            rv32i_pkg::op_auipc: res = pc + {ins[31:12], 12'b0};
            rv32i_pkg::op_load: begin
                addr  = a + b;
                lanes = lane_mask(f3, addr[1:0]);
                for (int k = 0; k < 4; k++) begin
                    word[8*k +: 8] = ref_mem[{addr[7:2], 2'(k)}];
                end
                res = word >> {addr[1:0], 3'b000};
                case (f3)
                    3'b000:  res = {{24{res[7]}}, res[7:0]};
                    3'b001:  res = {{16{res[15]}}, res[15:0]};
                    3'b100:  res = {24'b0, res[7:0]};
                    3'b101:  res = {16'b0, res[15:0]};
                    default: ;
                endcase
                exp_mem_q.push_back({addr, lanes, 4'b0000, 32'b0});
            end
            rv32i_pkg::op_store: begin
                addr  = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                lanes = lane_mask(f3, addr[1:0]);
                b     = x[ins[24:20]] << {addr[1:0], 3'b000};
                for (int k = 0; k < 4; k++) begin
                    if (lanes[k]) ref_mem[{addr[7:2], 2'(k)}] = b[8*k +: 8];
                end
                exp_mem_q.push_back({addr, 4'b0000, lanes, b});
                rd  = 5'd0;  // Stores retire without a register write
                res = '0;
            end
            default: begin
                if (ins[6:0] == rv32i_pkg::op_reg) b = x[ins[24:20]];
                res = alu_ref(f3, ins[30] && (ins[6:0] == rv32i_pkg::op_reg || f3 == 3'b101),
                              a, b);
            end
        endcase
        if (rd != 5'd0) x[rd] = res;  // x0 keeps reading zero
        exp_commit_q.push_back({pc, rd, res});
    end
endfunction

`endif

//--- dv/rv32i_cpu_tb.sv
`timescale 1ns/1ps

module rv32i_cpu_tb;

    logic        clk;
    logic        arst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_rdata;
    logic [31:0] imem_off;
    logic [31:0] dmem_addr;
    logic [3:0]  dmem_rmask;
    logic [3:0]  dmem_wmask;
    logic [31:0] dmem_wdata;
    logic [31:0] dmem_rdata;
    logic        commit_valid;
    logic [31:0] commit_pc;
    logic [4:0]  commit_rd;
    logic [31:0] commit_data;
    logic [7:0]  dmem [256];

    `include "rv32i_ref.svh"

    localparam int RUN_TIMEOUT = 2000;  // Cycles

    rv32i_cpu uut (
        .clk_i(clk), .arst_n_i(arst_n), .imem_addr_o(imem_addr), .imem_rdata_i(imem_rdata),
        .dmem_addr_o(dmem_addr), .dmem_rmask_o(dmem_rmask), .dmem_wmask_o(dmem_wmask),
        .dmem_wdata_o(dmem_wdata), .dmem_rdata_i(dmem_rdata),
        .commit_valid_o(commit_valid), .commit_pc_o(commit_pc),
        .commit_rd_o(commit_rd), .commit_data_o(commit_data)
    );

    // Both memories answer in the same cycle
    assign imem_off   = (imem_addr - rv32i_pkg::PC_RESET) >> 2;
    assign imem_rdata = (imem_off < IMEM_WORDS) ? prog[imem_off] : NOP_INSTR;
    assign dmem_rdata = {dmem[{dmem_addr[7:2], 2'd3}], dmem[{dmem_addr[7:2], 2'd2}],
                         dmem[{dmem_addr[7:2], 2'd1}], dmem[{dmem_addr[7:2], 2'd0}]};

    always @(posedge clk) begin
        for (int k = 0; k < 4; k++) begin
            if (dmem_wmask[k]) dmem[{dmem_addr[7:2], 2'(k)}] <= dmem_wdata[8*k +: 8];
        end
    end

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    task automatic stop_on_error(string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(string name, logic [31:0] want, logic [31:0] got);
        stop_on_error($sformatf("MISMATCH %s expected 0x%08h got 0x%08h", name, want, got));
    endtask

    task automatic verify_commit();
        commit_t want;
        assert (exp_commit_q.size() > 0)
            else stop_on_error("commit seen after the last expected instruction");
        want = exp_commit_q.pop_front();
        assert (commit_pc == want.pc) else report_mismatch("commit_pc_o", want.pc, commit_pc);
        assert (commit_rd == want.rd) else report_mismatch("commit_rd_o", want.rd, commit_rd);
        assert (commit_data == want.data)
            else report_mismatch("commit_data_o", want.data, commit_data);
    endtask

    task automatic compare_access();
        access_t     want;
        logic [31:0] lanes;
        assert (exp_mem_q.size() > 0)
            else stop_on_error("data memory access seen when none was expected");
        want  = exp_mem_q.pop_front();
        lanes = {{8{want.wmask[3]}}, {8{want.wmask[2]}}, {8{want.wmask[1]}}, {8{want.wmask[0]}}};
        assert (dmem_addr == want.addr) else report_mismatch("dmem_addr_o", want.addr, dmem_addr);
        assert (dmem_rmask == want.rmask)
            else report_mismatch("dmem_rmask_o", want.rmask, dmem_rmask);
        assert (dmem_wmask == want.wmask)
            else report_mismatch("dmem_wmask_o", want.wmask, dmem_wmask);
        assert ((dmem_wdata & lanes) == (want.wdata & lanes))
            else report_mismatch("dmem_wdata_o", want.wdata & lanes, dmem_wdata & lanes);
    endtask

    // Outputs are sampled mid-cycle
    always @(negedge clk) begin
        if (!arst_n) begin
            assert (commit_valid == 1'b0)
                else report_mismatch("commit_valid_o", 32'd0, commit_valid);
            assert (dmem_wmask == 4'h0) else report_mismatch("dmem_wmask_o", 32'd0, dmem_wmask);
        end else begin
            if (commit_valid) verify_commit();
            if (dmem_rmask != 4'h0 || dmem_wmask != 4'h0) compare_access();
        end
    end

    initial begin
        int cycles;
        void'($urandom(32'hbdbc_37ee));
        arst_n = 1'b0;
        for (int a = 0; a < 256; a++) begin
            dmem[a]    = fill_byte(a);
            ref_mem[a] = fill_byte(a);
        end
        gen_program();
        run_model();
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            if (i == 7) arst_n <= 1'b1;  // Eighth edge still sees reset
        end
        @(negedge clk);
        assert (imem_addr == rv32i_pkg::PC_RESET)
            else report_mismatch("imem_addr_o", rv32i_pkg::PC_RESET, imem_addr);
        cycles = 0;
        while ((exp_commit_q.size() > 0 || exp_mem_q.size() > 0) && cycles < RUN_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_commit_q.size() > 0 || exp_mem_q.size() > 0) begin
            stop_on_error("timed out waiting for the expected commits and memory accesses");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

//--- verilog/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic [rv32i_pkg::XLEN-1:0] a_i,
    input  logic [rv32i_pkg::XLEN-1:0] b_i,
    input  rv32i_pkg::alu_op_e         op_i,
    output logic [rv32i_pkg::XLEN-1:0] f_o
);

    logic [4:0] shamt;

    assign shamt = b_i[4:0];  // Shift amount from low bits only

    always_comb begin
        case (op_i)
            rv32i_pkg::alu_add:  f_o = a_i + b_i;
            rv32i_pkg::alu_sub:  f_o = a_i - b_i;
            rv32i_pkg::alu_sll:  f_o = a_i << shamt;
            rv32i_pkg::alu_slt:  f_o = rv32i_pkg::XLEN'($signed(a_i) < $signed(b_i));
            rv32i_pkg::alu_sltu: f_o = rv32i_pkg::XLEN'(a_i < b_i);
            rv32i_pkg::alu_xor:  f_o = a_i ^ b_i;
            rv32i_pkg::alu_srl:  f_o = a_i >> shamt;
            rv32i_pkg::alu_sra:  f_o = $unsigned($signed(a_i) >>> shamt);
            rv32i_pkg::alu_or:   f_o = a_i | b_i;
            rv32i_pkg::alu_and:  f_o = a_i & b_i;
            default:             f_o = '0;
        endcase
    end

endmodule

//--- verilog/ctrl_word.sv
`timescale 1ns/1ps

module ctrl_word (
    input  logic [rv32i_pkg::XLEN-1:0] instr_i,
    output rv32i_pkg::alu_op_e         alu_op_o,
    output rv32i_pkg::alu_a_sel_e      alu_a_sel_o,
    output rv32i_pkg::alu_b_sel_e      alu_b_sel_o,
    output logic                       mem_read_o,
    output logic                       mem_write_o,
    output logic [2:0]                 funct3_o,
    output rv32i_pkg::wb_sel_e         wb_sel_o,
    output logic                       reg_write_o
);

    // funct3 plus instr[30] select the ALU operation for OP and OP-IMM
    function automatic rv32i_pkg::alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? rv32i_pkg::alu_sub : rv32i_pkg::alu_add;
            3'b001:  return rv32i_pkg::alu_sll;
            3'b010:  return rv32i_pkg::alu_slt;
            3'b011:  return rv32i_pkg::alu_sltu;
            3'b100:  return rv32i_pkg::alu_xor;
            3'b101:  return alt ? rv32i_pkg::alu_sra : rv32i_pkg::alu_srl;
            3'b110:  return rv32i_pkg::alu_or;
            default: return rv32i_pkg::alu_and;
        endcase
    endfunction

    assign funct3_o = instr_i[14:12];

    always_comb begin
        alu_op_o    = rv32i_pkg::alu_add;  // Address add for loads and stores
        alu_a_sel_o = rv32i_pkg::a_rs1;
        alu_b_sel_o = rv32i_pkg::b_i_imm;
        mem_read_o  = 1'b0;
        mem_write_o = 1'b0;
        wb_sel_o    = rv32i_pkg::wb_alu;
        reg_write_o = 1'b0;

        case (instr_i[6:0])
            rv32i_pkg::op_lui: begin
                alu_b_sel_o = rv32i_pkg::b_u_imm;
                wb_sel_o    = rv32i_pkg::wb_u_imm;
                reg_write_o = 1'b1;
            end
            rv32i_pkg::op_auipc: begin
                alu_a_sel_o = rv32i_pkg::a_pc;
                alu_b_sel_o = rv32i_pkg::b_u_imm;
                reg_write_o = 1'b1;
            end
            rv32i_pkg::op_imm: begin
                // Only SRAI uses bit 30, ADDI has no subtract form
                alu_op_o    = arith_op(funct3_o, (funct3_o == 3'b101) && instr_i[30]);
                reg_write_o = 1'b1;
            end
            rv32i_pkg::op_reg: begin
                alu_op_o    = arith_op(funct3_o, instr_i[30]);
                alu_b_sel_o = rv32i_pkg::b_rs2;
                reg_write_o = 1'b1;
            end
            rv32i_pkg::op_load: begin
                mem_read_o  = 1'b1;
                wb_sel_o    = rv32i_pkg::wb_load;
                reg_write_o = 1'b1;
            end
            rv32i_pkg::op_store: begin
                alu_b_sel_o = rv32i_pkg::b_s_imm;
                mem_write_o = 1'b1;
            end
            default: ;  // Unsupported opcode passes as a bubble
        endcase
    end

endmodule

//--- verilog/datapath.sv
`timescale 1ns/1ps

module datapath (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    output logic [rv32i_pkg::XLEN-1:0] imem_addr_o,
    input  logic [rv32i_pkg::XLEN-1:0] imem_rdata_i,
    output logic [rv32i_pkg::XLEN-1:0] dmem_addr_o,
    output logic [3:0]                 dmem_rmask_o,
    output logic [3:0]                 dmem_wmask_o,
    output logic [rv32i_pkg::XLEN-1:0] dmem_wdata_o,
    input  logic [rv32i_pkg::XLEN-1:0] dmem_rdata_i,
    output logic                       commit_valid_o,
    output logic [rv32i_pkg::XLEN-1:0] commit_pc_o,
    output logic [4:0]                 commit_rd_o,
    output logic [rv32i_pkg::XLEN-1:0] commit_data_o,
    output logic [rv32i_pkg::XLEN-1:0] id_ir_o,
    input  rv32i_pkg::alu_op_e         alu_op_i,
    input  rv32i_pkg::alu_a_sel_e      alu_a_sel_i,
    input  rv32i_pkg::alu_b_sel_e      alu_b_sel_i,
    input  logic                       mem_read_i,
    input  logic                       mem_write_i,
    input  logic [2:0]                 funct3_i,
    input  rv32i_pkg::wb_sel_e         wb_sel_i,
    input  logic                       reg_write_i,
    output logic [4:0]                 id_rs1_o,
    output logic [4:0]                 id_rs2_o,
    output logic [4:0]                 ex_rs1_o,
    output logic [4:0]                 ex_rs2_o,
    output logic [4:0]                 ex_rd_o,
    output logic                       ex_mem_read_o,
    output logic [4:0]                 mem_rd_o,
    output logic                       mem_reg_write_o,
    output logic [4:0]                 wb_rd_o,
    output logic                       wb_reg_write_o,
    input  rv32i_pkg::fwd_sel_e        fwd_a_i,
    input  rv32i_pkg::fwd_sel_e        fwd_b_i,
    input  logic                       stall_i,
    input  logic [rv32i_pkg::XLEN-1:0] rs1_data_i,
    input  logic [rv32i_pkg::XLEN-1:0] rs2_data_i,
    output logic                       rf_we_o,
    output logic [4:0]                 rf_waddr_o,
    output logic [rv32i_pkg::XLEN-1:0] rf_wdata_o,
    output logic [rv32i_pkg::XLEN-1:0] alu_a_o,
    output logic [rv32i_pkg::XLEN-1:0] alu_b_o,
    output rv32i_pkg::alu_op_e         alu_op_o,
    input  logic [rv32i_pkg::XLEN-1:0] alu_f_i
);

    logic [rv32i_pkg::XLEN-1:0] pc, if_id_pc, if_id_ir;
    logic [rv32i_pkg::XLEN-1:0] id_ex_pc, id_ex_ir, id_ex_rs1, id_ex_rs2;
    logic [rv32i_pkg::XLEN-1:0] ex_mem_pc, ex_mem_res, ex_mem_sdata;
    logic [rv32i_pkg::XLEN-1:0] mem_wb_pc, mem_wb_res, mem_wb_rdata;
    logic [rv32i_pkg::XLEN-1:0] i_imm, s_imm, u_imm, rs1_fwd, rs2_fwd;
    logic [rv32i_pkg::XLEN-1:0] ex_res, load_shifted, load_data, wb_data;
    logic if_id_valid, id_ex_valid, ex_mem_valid, mem_wb_valid;
    logic id_ex_mem_read, id_ex_mem_write, id_ex_reg_write;
    logic ex_mem_mem_read, ex_mem_mem_write, ex_mem_reg_write;
    logic mem_wb_mem_read, mem_wb_reg_write;
    logic [2:0] id_ex_funct3, ex_mem_funct3, mem_wb_funct3;
    logic [4:0] ex_mem_rd, mem_wb_rd;
    logic [1:0] mem_wb_addr_lo;
    rv32i_pkg::alu_op_e    id_ex_alu_op;
    rv32i_pkg::alu_a_sel_e id_ex_a_sel;
    rv32i_pkg::alu_b_sel_e id_ex_b_sel;
    rv32i_pkg::wb_sel_e    id_ex_wb_sel;

    // Valid bits and PC; a stall holds fetch and drops a bubble into ID/EX
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc           <= rv32i_pkg::PC_RESET;
            if_id_valid  <= 1'b0;
            id_ex_valid  <= 1'b0;
            ex_mem_valid <= 1'b0;
            mem_wb_valid <= 1'b0;
        end else begin
            if (!stall_i) begin
                pc          <= pc + 32'd4;
                if_id_valid <= 1'b1;
            end
            id_ex_valid  <= if_id_valid && !stall_i;
            ex_mem_valid <= id_ex_valid;
            mem_wb_valid <= ex_mem_valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            if_id_pc <= pc;
            if_id_ir <= imem_rdata_i;
        end
        id_ex_pc         <= if_id_pc;
        id_ex_ir         <= if_id_ir;
        id_ex_rs1        <= rs1_data_i;
        id_ex_rs2        <= rs2_data_i;
        id_ex_alu_op     <= alu_op_i;
        id_ex_a_sel      <= alu_a_sel_i;
        id_ex_b_sel      <= alu_b_sel_i;
        id_ex_mem_read   <= mem_read_i;
        id_ex_mem_write  <= mem_write_i;
        id_ex_funct3     <= funct3_i;
        id_ex_wb_sel     <= wb_sel_i;
        id_ex_reg_write  <= reg_write_i;
        ex_mem_pc        <= id_ex_pc;
        ex_mem_rd        <= id_ex_ir[11:7];
        ex_mem_res       <= ex_res;
        ex_mem_sdata     <= rs2_fwd;
        ex_mem_mem_read  <= id_ex_mem_read;
        ex_mem_mem_write <= id_ex_mem_write;
        ex_mem_funct3    <= id_ex_funct3;
        ex_mem_reg_write <= id_ex_reg_write;
        mem_wb_pc        <= ex_mem_pc;
        mem_wb_rd        <= ex_mem_rd;
        mem_wb_res       <= ex_mem_res;
        mem_wb_rdata     <= dmem_rdata_i;
        mem_wb_addr_lo   <= ex_mem_res[1:0];  // Byte offset for load extension
        mem_wb_mem_read  <= ex_mem_mem_read;
        mem_wb_funct3    <= ex_mem_funct3;
        mem_wb_reg_write <= ex_mem_reg_write;
    end

    assign imem_addr_o = pc;
    assign id_ir_o     = if_id_ir;
    assign id_rs1_o    = if_id_ir[19:15];
    assign id_rs2_o    = if_id_ir[24:20];

    assign ex_rs1_o        = id_ex_ir[19:15];
    assign ex_rs2_o        = id_ex_ir[24:20];
    assign ex_rd_o         = id_ex_ir[11:7];
    assign ex_mem_read_o   = id_ex_valid && id_ex_mem_read;
    assign mem_rd_o        = ex_mem_rd;
    assign mem_reg_write_o = ex_mem_valid && ex_mem_reg_write;
    assign wb_rd_o         = mem_wb_rd;
    assign wb_reg_write_o  = mem_wb_valid && mem_wb_reg_write;

    assign i_imm = {{20{id_ex_ir[31]}}, id_ex_ir[31:20]};
    assign s_imm = {{20{id_ex_ir[31]}}, id_ex_ir[31:25], id_ex_ir[11:7]};
    assign u_imm = {id_ex_ir[31:12], 12'b0};

    always_comb begin
        case (fwd_a_i)
            rv32i_pkg::fwd_mem: rs1_fwd = ex_mem_res;
            rv32i_pkg::fwd_wb:  rs1_fwd = wb_data;
            default:            rs1_fwd = id_ex_rs1;
        endcase
        case (fwd_b_i)
            rv32i_pkg::fwd_mem: rs2_fwd = ex_mem_res;
            rv32i_pkg::fwd_wb:  rs2_fwd = wb_data;
            default:            rs2_fwd = id_ex_rs2;
        endcase
        case (id_ex_b_sel)
            rv32i_pkg::b_rs2:   alu_b_o = rs2_fwd;
            rv32i_pkg::b_i_imm: alu_b_o = i_imm;
            rv32i_pkg::b_s_imm: alu_b_o = s_imm;
            default:            alu_b_o = u_imm;
        endcase
    end

    assign alu_a_o  = (id_ex_a_sel == rv32i_pkg::a_pc) ? id_ex_pc : rs1_fwd;
    assign alu_op_o = id_ex_alu_op;
    assign ex_res   = (id_ex_wb_sel == rv32i_pkg::wb_u_imm) ? u_imm : alu_f_i;  // LUI result

    assign dmem_addr_o = ex_mem_res;

    // Lane masks and store data follow the low address bits
    always_comb begin
        dmem_rmask_o = 4'b0000;
        dmem_wmask_o = 4'b0000;
        dmem_wdata_o = ex_mem_sdata;
        if (ex_mem_valid && ex_mem_mem_read) begin
            case (rv32i_pkg::load_funct3_e'(ex_mem_funct3))
                rv32i_pkg::lw:               dmem_rmask_o = 4'b1111;
                rv32i_pkg::lh, rv32i_pkg::lhu: dmem_rmask_o = 4'b0011 << {ex_mem_res[1], 1'b0};
                rv32i_pkg::lb, rv32i_pkg::lbu: dmem_rmask_o = 4'b0001 << ex_mem_res[1:0];
                default: ;
            endcase
        end
        if (ex_mem_valid && ex_mem_mem_write) begin
            case (rv32i_pkg::store_funct3_e'(ex_mem_funct3))
                rv32i_pkg::sw: dmem_wmask_o = 4'b1111;
                rv32i_pkg::sh: begin
                    dmem_wmask_o = 4'b0011 << {ex_mem_res[1], 1'b0};
                    dmem_wdata_o = ex_mem_sdata << {ex_mem_res[1], 4'b0000};
                end
                rv32i_pkg::sb: begin
                    dmem_wmask_o = 4'b0001 << ex_mem_res[1:0];
                    dmem_wdata_o = ex_mem_sdata << {ex_mem_res[1:0], 3'b000};
                end
                default: ;
            endcase
        end
    end

    assign load_shifted = mem_wb_rdata >> {mem_wb_addr_lo, 3'b000};

    always_comb begin
        case (rv32i_pkg::load_funct3_e'(mem_wb_funct3))
            rv32i_pkg::lb:  load_data = {{24{load_shifted[7]}}, load_shifted[7:0]};
            rv32i_pkg::lbu: load_data = {24'b0, load_shifted[7:0]};
            rv32i_pkg::lh:  load_data = {{16{load_shifted[15]}}, load_shifted[15:0]};
            rv32i_pkg::lhu: load_data = {16'b0, load_shifted[15:0]};
            default:        load_data = mem_wb_rdata;
        endcase
    end

    assign wb_data    = mem_wb_mem_read ? load_data : mem_wb_res;
    assign rf_we_o    = mem_wb_valid && mem_wb_reg_write;
    assign rf_waddr_o = mem_wb_rd;
    assign rf_wdata_o = wb_data;

    assign commit_valid_o = mem_wb_valid;
    assign commit_pc_o    = mem_wb_pc;
    assign commit_rd_o    = mem_wb_reg_write ? mem_wb_rd : 5'd0;
    assign commit_data_o  = mem_wb_reg_write ? wb_data : '0;

    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(|dmem_wmask_o && |dmem_rmask_o))
        else $error("read and write masks both active");

    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        commit_valid_o |-> !$isunknown(commit_data_o))
        else $error("commit with unknown data");

endmodule

//--- verilog/hazard_ctrl.sv
`timescale 1ns/1ps

module hazard_ctrl (
    input  logic [4:0]               id_rs1_i,
    input  logic [4:0]               id_rs2_i,
    input  logic [4:0]               ex_rs1_i,
    input  logic [4:0]               ex_rs2_i,
    input  logic [4:0]               ex_rd_i,
    input  logic                     ex_mem_read_i,
    input  logic [4:0]               mem_rd_i,
    input  logic                     mem_reg_write_i,
    input  logic [4:0]               wb_rd_i,
    input  logic                     wb_reg_write_i,
    output rv32i_pkg::fwd_sel_e      fwd_a_o,
    output rv32i_pkg::fwd_sel_e      fwd_b_o,
    output logic                     stall_o
);

    logic mem_live;
    logic wb_live;

    assign mem_live = mem_reg_write_i && (mem_rd_i != 5'd0);
    assign wb_live  = wb_reg_write_i && (wb_rd_i != 5'd0);

    // Memory stage holds the newer value, so it wins over writeback
    always_comb begin
        if (mem_live && mem_rd_i == ex_rs1_i) begin
            fwd_a_o = rv32i_pkg::fwd_mem;
        end else if (wb_live && wb_rd_i == ex_rs1_i) begin
            fwd_a_o = rv32i_pkg::fwd_wb;
        end else begin
            fwd_a_o = rv32i_pkg::fwd_none;
        end

        if (mem_live && mem_rd_i == ex_rs2_i) begin
            fwd_b_o = rv32i_pkg::fwd_mem;
        end else if (wb_live && wb_rd_i == ex_rs2_i) begin
            fwd_b_o = rv32i_pkg::fwd_wb;
        end else begin
            fwd_b_o = rv32i_pkg::fwd_none;
        end
    end

    // Load data exists only after the memory stage so one bubble is needed
    assign stall_o = ex_mem_read_i && (ex_rd_i != 5'd0) &&
                     (ex_rd_i == id_rs1_i || ex_rd_i == id_rs2_i);

endmodule

//--- verilog/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    input  logic                       we_i,
    input  logic [4:0]                 waddr_i,
    input  logic [rv32i_pkg::XLEN-1:0] wdata_i,
    input  logic [4:0]                 raddr1_i,
    input  logic [4:0]                 raddr2_i,
    output logic [rv32i_pkg::XLEN-1:0] rdata1_o,
    output logic [rv32i_pkg::XLEN-1:0] rdata2_o
);

    logic [rv32i_pkg::XLEN-1:0] regs [1:31];  // x0 is not stored

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != 5'd0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Write-through so decode sees the value retiring this cycle
    assign rdata1_o = (raddr1_i == 5'd0) ? '0 :
                      (we_i && waddr_i == raddr1_i) ? wdata_i : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == 5'd0) ? '0 :
                      (we_i && waddr_i == raddr2_i) ? wdata_i : regs[raddr2_i];

endmodule

//--- verilog/rv32i_cpu.sv
`timescale 1ns/1ps

module rv32i_cpu (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    output logic [rv32i_pkg::XLEN-1:0] imem_addr_o,
    input  logic [rv32i_pkg::XLEN-1:0] imem_rdata_i,
    output logic [rv32i_pkg::XLEN-1:0] dmem_addr_o,
    output logic [3:0]                 dmem_rmask_o,
    output logic [3:0]                 dmem_wmask_o,
    output logic [rv32i_pkg::XLEN-1:0] dmem_wdata_o,
    input  logic [rv32i_pkg::XLEN-1:0] dmem_rdata_i,
    output logic                       commit_valid_o,
    output logic [rv32i_pkg::XLEN-1:0] commit_pc_o,
    output logic [4:0]                 commit_rd_o,
    output logic [rv32i_pkg::XLEN-1:0] commit_data_o
);

    logic [rv32i_pkg::XLEN-1:0] id_ir, rs1_data, rs2_data, rf_wdata, alu_a, alu_b, alu_f;
    logic [4:0] id_rs1, id_rs2, ex_rs1, ex_rs2, ex_rd, mem_rd, wb_rd, rf_waddr;
    logic [2:0] funct3;
    logic mem_read, mem_write, reg_write, ex_mem_read, mem_reg_write, wb_reg_write;
    logic stall, rf_we;
    rv32i_pkg::alu_op_e    alu_op, alu_op_ex;
    rv32i_pkg::alu_a_sel_e alu_a_sel;
    rv32i_pkg::alu_b_sel_e alu_b_sel;
    rv32i_pkg::wb_sel_e    wb_sel;
    rv32i_pkg::fwd_sel_e   fwd_a, fwd_b;

    datapath u_datapath (
        .clk_i, .arst_n_i, .imem_addr_o, .imem_rdata_i,
        .dmem_addr_o, .dmem_rmask_o, .dmem_wmask_o, .dmem_wdata_o, .dmem_rdata_i,
        .commit_valid_o, .commit_pc_o, .commit_rd_o, .commit_data_o,
        .id_ir_o(id_ir), .alu_op_i(alu_op), .alu_a_sel_i(alu_a_sel), .alu_b_sel_i(alu_b_sel),
        .mem_read_i(mem_read), .mem_write_i(mem_write), .funct3_i(funct3),
        .wb_sel_i(wb_sel), .reg_write_i(reg_write),
        .id_rs1_o(id_rs1), .id_rs2_o(id_rs2), .ex_rs1_o(ex_rs1), .ex_rs2_o(ex_rs2),
        .ex_rd_o(ex_rd), .ex_mem_read_o(ex_mem_read), .mem_rd_o(mem_rd),
        .mem_reg_write_o(mem_reg_write), .wb_rd_o(wb_rd), .wb_reg_write_o(wb_reg_write),
        .fwd_a_i(fwd_a), .fwd_b_i(fwd_b), .stall_i(stall),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .rf_we_o(rf_we), .rf_waddr_o(rf_waddr), .rf_wdata_o(rf_wdata),
        .alu_a_o(alu_a), .alu_b_o(alu_b), .alu_op_o(alu_op_ex), .alu_f_i(alu_f)
    );

    ctrl_word u_ctrl_word (
        .instr_i(id_ir), .alu_op_o(alu_op), .alu_a_sel_o(alu_a_sel), .alu_b_sel_o(alu_b_sel),
        .mem_read_o(mem_read), .mem_write_o(mem_write), .funct3_o(funct3),
        .wb_sel_o(wb_sel), .reg_write_o(reg_write)
    );

    hazard_ctrl u_hazard_ctrl (
        .id_rs1_i(id_rs1), .id_rs2_i(id_rs2), .ex_rs1_i(ex_rs1), .ex_rs2_i(ex_rs2),
        .ex_rd_i(ex_rd), .ex_mem_read_i(ex_mem_read), .mem_rd_i(mem_rd),
        .mem_reg_write_i(mem_reg_write), .wb_rd_i(wb_rd), .wb_reg_write_i(wb_reg_write),
        .fwd_a_o(fwd_a), .fwd_b_o(fwd_b), .stall_o(stall)
    );

    regfile u_regfile (
        .clk_i, .arst_n_i, .we_i(rf_we), .waddr_i(rf_waddr), .wdata_i(rf_wdata),
        .raddr1_i(id_rs1), .raddr2_i(id_rs2), .rdata1_o(rs1_data), .rdata2_o(rs2_data)
    );

    alu u_alu (.a_i(alu_a), .b_i(alu_b), .op_i(alu_op_ex), .f_o(alu_f));

endmodule

//--- verilog/rv32i_pkg.sv
package rv32i_pkg;

    localparam int XLEN = 32;
    localparam logic [XLEN-1:0] PC_RESET = 32'h4000_0000;  // First fetch address

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011
    } rv32i_opcode_e;

    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3_e;

    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct3_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_e;

    typedef enum logic {a_rs1, a_pc} alu_a_sel_e;

    typedef enum logic [1:0] {b_rs2, b_i_imm, b_s_imm, b_u_imm} alu_b_sel_e;

    // Execute operand source when a later stage holds a newer value
    typedef enum logic [1:0] {fwd_none, fwd_mem, fwd_wb} fwd_sel_e;

    typedef enum logic [1:0] {wb_alu, wb_load, wb_u_imm} wb_sel_e;

endpackage
